// ==== all.f ====
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instMem.sv
hdl/registerFile.sv
hdl/dataMem.sv
hdl/instDecoder.sv
hdl/alu.sv
hdl/pcUnit.sv
hdl/singleCpu.sv
test/cpuMonitor.sv
test/singleCpu_checker.sv
test/singleCpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the singleCpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f all.f --top-module singleCpuTb -o singleCpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/singleCpuSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== test/singleCpuTb.sv ====
module singleCpuTb import isaPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int imemWords   = 64;
    localparam int dmemWords   = 64;
    localparam int iAddrW      = $clog2(imemWords);
    localparam int runCycles   = 2000;
    localparam int resetCycles = 5;

    logic              CLK;
    logic              rstN;
    logic              progWe;
    logic [iAddrW-1:0] progAddr;
    logic [xlen-1:0]   progData;
    logic [xlen-1:0]   pcOut;
    logic [xlen-1:0]   instOut;
    logic              regWe;
    logic [4:0]        regAddr;
    logic [xlen-1:0]   regData;
    logic              memWe;
    logic [xlen-1:0]   memAddr;
    logic [xlen-1:0]   memData;
    logic              monDone;
    int                monErrors;

    singleCpu #(.imemWords(imemWords), .dmemWords(dmemWords)) i_dut (
        .CLK(CLK), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pcOut(pcOut), .instOut(instOut), .regWe(regWe), .regAddr(regAddr),
        .regData(regData), .memWe(memWe), .memAddr(memAddr), .memData(memData)
    );

    cpuMonitor #(.imemWords(imemWords), .dmemWords(dmemWords), .runCycles(runCycles)) monitor (
        .CLK(CLK), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pcOut(pcOut), .instOut(instOut), .regWe(regWe), .regAddr(regAddr),
        .regData(regData), .memWe(memWe), .memAddr(memAddr), .memData(memData),
        .done(monDone), .errors(monErrors)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // One random word from the subset with about 1 in 12 an unknown opcode
    function automatic logic [31:0] randInst();
        int unsigned kind;
        int          off;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [12:0] bImm;
        logic [6:0]  op;

        kind  = $urandom % 12;
        rd    = 5'($urandom % 8);  // Small register pool for more reuse
        rs1   = 5'($urandom % 8);
        rs2   = 5'($urandom % 8);
        imm12 = 12'($urandom);
        if (kind == 0) begin
            do begin
                op = 7'($urandom);
            end while (op == opR || op == opImm || op == opLoad || op == opStore
                       || op == opBranch);
            return {25'($urandom), op};
        end else if (kind <= 3) begin
            case ($urandom % 5)
                0:       return {7'b0000000, rs2, rs1, f3AddSub, rd, opR};
                1:       return {7'b0100000, rs2, rs1, f3AddSub, rd, opR};  // sub
                2:       return {7'b0000000, rs2, rs1, f3And, rd, opR};
                3:       return {7'b0000000, rs2, rs1, f3Or, rd, opR};
                default: return {7'b0000000, rs2, rs1, f3Slt, rd, opR};
            endcase
        end else if (kind <= 5) begin
            return {imm12, rs1, f3AddSub, rd, opImm};
        end else if (kind <= 7) begin
            return {imm12, rs1, f3Word, rd, opLoad};
        end else if (kind <= 9) begin
            return {imm12[11:5], rs2, rs1, f3Word, imm12[4:0], opStore};
        end
        off = int'($urandom % 33) - 16;  // Up to 16 words either way
        if (off == 0) begin
            off = 1;
        end
        bImm = 13'(off * 4);
        return {bImm[12], bImm[10:5], rs2, rs1, f3Beq, bImm[4:1], bImm[11], opBranch};
    endfunction

    initial begin
        int waitCycles;
        int timeouts;
        int totalErrors;

        rstN     = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        timeouts = 0;
        void'($urandom(46));

        // Program load with the core held in reset
        for (int i = 0; i < imemWords; i++) begin
            @(posedge CLK);
            #1;
            progWe   = 1'b1;
            progAddr = iAddrW'(i);
            progData = randInst();
        end
        @(posedge CLK);
        #1;
        progWe = 1'b0;
        repeat (resetCycles) @(posedge CLK);
        #1;
        rstN = 1'b1;

        waitCycles = 0;
        while (!monDone && waitCycles < runCycles + 50) begin
            @(posedge CLK);
            waitCycles++;
        end
        if (!monDone) begin
            timeouts++;
            $display("Timeout: monitor did not finish within %0d cycles", waitCycles);
        end

        totalErrors = monErrors + timeouts;
        $display("Errors: %0d total, %0d mismatches, %0d timeouts", totalErrors, monErrors,
                 timeouts);
        if (totalErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== test/singleCpu_checker.sv ====
module singleCpuChecker import isaPkg::*; (
    input logic               CLK,
    input logic               rstN,
    input logic [xlen-1:0]    pc,
    input logic               regWe,
    input logic [regIdxW-1:0] regAddr,
    input logic               memWe,
    input logic [xlen-1:0]    x0Value
);
    timeunit 1ns;
    timeprecision 100ps;

    resetQuiet: assert property (@(posedge CLK) !rstN |-> (!regWe && !memWe))
        else $error("Write enable high while reset is asserted");

    pcAligned: assert property (@(posedge CLK) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("PC is not word-aligned");

    // Single-cycle core never writes both in one instruction
    oneWrite: assert property (@(posedge CLK) disable iff (!rstN) !(regWe && memWe))
        else $error("Register write and memory write in the same cycle");

    x0Stays: assert property (@(posedge CLK) disable iff (!rstN)
        (regWe && regAddr == '0) |=> (x0Value == '0))
        else $error("Register x0 changed after a write to it");

endmodule

bind singleCpu singleCpuChecker cpuChecker (
    .CLK(CLK), .rstN(rstN), .pc(pc), .regWe(regWe), .regAddr(regAddr), .memWe(memWe),
    .x0Value(registerFile1.regs[0])
);

// ==== test/cpuMonitor.sv ====
module cpuMonitor import isaPkg::*; #(
    parameter int imemWords = 64,
    parameter int dmemWords = 64,
    parameter int runCycles = 2000
) (
    input  logic                         CLK,
    input  logic                         rstN,
    input  logic                         progWe,
    input  logic [$clog2(imemWords)-1:0] progAddr,
    input  logic [xlen-1:0]              progData,
    input  logic [xlen-1:0]              pcOut,
    input  logic [xlen-1:0]              instOut,
    input  logic                         regWe,
    input  logic [regIdxW-1:0]           regAddr,
    input  logic [xlen-1:0]              regData,
    input  logic                         memWe,
    input  logic [xlen-1:0]              memAddr,
    input  logic [xlen-1:0]              memData,
    output logic                         done,
    output int                           errors
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int iAddrW = $clog2(imemWords);
    localparam int dAddrW = $clog2(dmemWords);

    logic [xlen-1:0] prog [imemWords];  // Copy of the loaded program
    logic [xlen-1:0] regsM [32];
    logic [xlen-1:0] dmemM [dmemWords];
    logic [xlen-1:0] pcM;
    logic            doneFlag = 1'b0;
    int              errCount = 0;
    int              cycles = 0;

    assign done   = doneFlag;
    assign errors = errCount;

    task automatic checkValue(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            errCount++;
            $display("Fail %s at cycle %0d: expected %h, actual %h", name, cycles, expected,
                     actual);
        end
    endtask

    // Same words the DUT sees on its program port
    always @(posedge CLK) begin
        if (!rstN && progWe) begin
            prog[progAddr] <= progData;
        end
    end

    task automatic stepModel();
        logic [xlen-1:0]   inst;
        logic [xlen-1:0]   a;
        logic [xlen-1:0]   b;
        logic [xlen-1:0]   res;
        logic [xlen-1:0]   addr;
        logic [xlen-1:0]   nextPc;
        logic [xlen-1:0]   iImm;
        logic [xlen-1:0]   sImm;
        logic [xlen-1:0]   bImm;
        logic [iAddrW-1:0] fetchIdx;
        logic [dAddrW-1:0] dataIdx;
        logic [6:0]        op;
        logic [2:0]        f3;
        logic [4:0]        rd;
        logic              expRegWe;
        logic              expMemWe;

        fetchIdx = iAddrW'((pcM >> 2) % xlen'(imemWords));  // Fetch wraps
        inst     = prog[fetchIdx];
        op       = inst[6:0];
        f3       = inst[14:12];
        rd       = inst[11:7];
        a        = (inst[19:15] == 5'd0) ? '0 : regsM[inst[19:15]];
        b        = (inst[24:20] == 5'd0) ? '0 : regsM[inst[24:20]];
        iImm     = {{20{inst[31]}}, inst[31:20]};
        sImm     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        bImm     = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        res      = '0;
        addr     = '0;
        nextPc   = pcM + 32'd4;
        expRegWe = 1'b0;
        expMemWe = 1'b0;

        case (op)
            opR: begin
                expRegWe = 1'b1;
                case (f3)
                    f3AddSub: res = inst[30] ? a - b : a + b;
                    f3Slt:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    f3Or:     res = a | b;
                    f3And:    res = a & b;
                    default:  expRegWe = 1'b0;
                endcase
            end
            opImm: begin
                expRegWe = (f3 == f3AddSub);
                res      = a + iImm;
            end
            opLoad: begin
                expRegWe = (f3 == f3Word);
                addr     = a + iImm;
                dataIdx  = dAddrW'((addr >> 2) % xlen'(dmemWords));
                res      = dmemM[dataIdx];
            end
            opStore: begin
                expMemWe = (f3 == f3Word);
                addr     = a + sImm;
            end
            opBranch: begin
                if (f3 == f3Beq && a == b) begin
                    nextPc = pcM + bImm;
                end
            end
            default: ;  // No-op
        endcase

        checkValue("pcOut", pcM, pcOut);
        checkValue("instOut", inst, instOut);
        checkValue("regWe", 32'(expRegWe), 32'(regWe));
        if (expRegWe) begin
            checkValue("regAddr", 32'(rd), 32'(regAddr));
            checkValue("regData", res, regData);
        end
        checkValue("memWe", 32'(expMemWe), 32'(memWe));
        if (expMemWe) begin
            checkValue("memAddr", addr, memAddr);
            checkValue("memData", b, memData);
        end

        if (expRegWe && rd != 5'd0) begin
            regsM[rd] = res;
        end
        if (expMemWe) begin
            dataIdx        = dAddrW'((addr >> 2) % xlen'(dmemWords));
            dmemM[dataIdx] = b;
        end
        pcM = nextPc;
    endtask

    // Outputs are settled by the falling edge
    always @(negedge CLK) begin
        if (!rstN) begin
            checkValue("reset pcOut", '0, pcOut);
            checkValue("reset regWe", '0, 32'(regWe));
            checkValue("reset memWe", '0, 32'(memWe));
            pcM = '0;
            for (int i = 0; i < 32; i++) begin
                regsM[i] = '0;
            end
            for (int i = 0; i < dmemWords; i++) begin
                dmemM[i] = '0;
            end
        end else if (!doneFlag) begin
            stepModel();
            cycles++;
            if (cycles == runCycles) begin
                doneFlag = 1'b1;
            end
        end
    end

endmodule

// ==== hdl/singleCpu.sv ====
module singleCpu import isaPkg::*, ctrlPkg::*; #(
    parameter int imemWords = 64,
    parameter int dmemWords = 64
) (
    input  logic                         CLK,
    input  logic                         rstN,
    input  logic                         progWe,
    input  logic [$clog2(imemWords)-1:0] progAddr,
    input  logic [xlen-1:0]              progData,
    output logic [xlen-1:0]              pcOut,
    output logic [xlen-1:0]              instOut,
    output logic                         regWe,
    output logic [regIdxW-1:0]           regAddr,
    output logic [xlen-1:0]              regData,
    output logic                         memWe,
    output logic [xlen-1:0]              memAddr,
    output logic [xlen-1:0]              memData
);

    logic [xlen-1:0]    pc;
    logic [xlen-1:0]    inst;
    logic [regIdxW-1:0] rs1;
    logic [regIdxW-1:0] rs2;
    logic [regIdxW-1:0] rd;
    logic [xlen-1:0]    imm;
    aluOpE              aluOp;
    logic               aluSrc;
    logic               regWrite;
    logic               memWrite;
    wbSelE              wbSel;
    logic               branch;
    logic [xlen-1:0]    rd1;
    logic [xlen-1:0]    rd2;
    logic [xlen-1:0]    result;
    logic               zero;
    logic [xlen-1:0]    wbData;

    pcUnit pcUnit1 (.CLK(CLK), .rstN(rstN), .branch(branch), .zero(zero), .imm(imm), .pc(pc));

    // Program port only open while the core is held in reset
    instMem #(.imemWords(imemWords)) instMem1 (
        .CLK(CLK), .progWe(progWe & ~rstN), .progAddr(progAddr), .progData(progData),
        .pc(pc), .inst(inst)
    );

    instDecoder instDecoder1 (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .aluOp(aluOp),
        .aluSrc(aluSrc), .regWrite(regWrite), .memWrite(memWrite), .wbSel(wbSel),
        .branch(branch)
    );

    registerFile registerFile1 (
        .CLK(CLK), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rd(rd), .regWrite(regWrite),
        .wbData(wbData), .rd1(rd1), .rd2(rd2)
    );

    alu alu1 (
        .rd1(rd1), .rd2(rd2), .imm(imm), .aluSrc(aluSrc), .aluOp(aluOp),
        .result(result), .zero(zero)
    );

    dataMem #(.dmemWords(dmemWords)) dataMem1 (
        .CLK(CLK), .rstN(rstN), .memWrite(memWrite), .wbSel(wbSel), .aluResult(result),
        .storeData(rd2), .wbData(wbData)
    );

    // Per-cycle trace of the executing instruction
    assign pcOut   = pc;
    assign instOut = inst;
    assign regWe   = regWrite & rstN;  // Quiet while the program loads
    assign regAddr = rd;
    assign regData = wbData;
    assign memWe   = memWrite & rstN;
    assign memAddr = result;
    assign memData = rd2;

endmodule

// ==== hdl/pcUnit.sv ====
module pcUnit import isaPkg::*; (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            branch,
    input  logic            zero,
    input  logic [xlen-1:0] imm,
    output logic [xlen-1:0] pc
);

    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] branchTarget;
    logic            takeBranch;

    assign pcPlus4      = pc + xlen'(4);
    assign branchTarget = pc + imm;  // imm already shifted by one
    assign takeBranch   = branch & zero;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= takeBranch ? branchTarget : pcPlus4;
        end
    end

endmodule

// ==== hdl/alu.sv ====
module alu import isaPkg::*, ctrlPkg::*; (
    input  logic [xlen-1:0] rd1,
    input  logic [xlen-1:0] rd2,
    input  logic [xlen-1:0] imm,
    input  logic            aluSrc,
    input  aluOpE           aluOp,
    output logic [xlen-1:0] result,
    output logic            zero
);

    logic [xlen-1:0] opB;

    assign opB = aluSrc ? imm : rd2;  // Immediate for addi, lw, sw

    always_comb begin
        case (aluOp)
            aluAdd:  result = rd1 + opB;
            aluSub:  result = rd1 - opB;
            aluAnd:  result = rd1 & opB;
            aluOr:   result = rd1 | opB;
            aluSlt:  result = {{(xlen-1){1'b0}}, $signed(rd1) < $signed(opB)};
            default: result = '0;
        endcase
    end

    // Branch condition for beq
    assign zero = (result == '0);

endmodule

// ==== hdl/instDecoder.sv ====
module instDecoder import isaPkg::*, ctrlPkg::*; (
    input  logic [xlen-1:0]    inst,
    output logic [regIdxW-1:0] rs1,
    output logic [regIdxW-1:0] rs2,
    output logic [regIdxW-1:0] rd,
    output logic [xlen-1:0]    imm,
    output aluOpE              aluOp,
    output logic               aluSrc,
    output logic               regWrite,
    output logic               memWrite,
    output wbSelE              wbSel,
    output logic               branch
);

    funct3E          funct3;
    logic [xlen-1:0] iImm;
    logic [xlen-1:0] sImm;
    logic [xlen-1:0] bImm;

    // Register indices straight from the instruction fields
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];
    assign funct3 = funct3E'(inst[14:12]);

    // Sign-extended immediates
    assign iImm = {{(xlen-12){inst[31]}}, inst[31:20]};
    assign sImm = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign bImm = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        // Defaults give a no-op
        imm      = iImm;
        aluOp    = aluAdd;
        aluSrc   = 1'b0;
        regWrite = 1'b0;
        memWrite = 1'b0;
        wbSel    = wbAlu;
        branch   = 1'b0;

        case (opcodeE'(inst[6:0]))
            opR: begin
                regWrite = 1'b1;
                case (funct3)
                    f3AddSub: aluOp = inst[30] ? aluSub : aluAdd;
                    f3Slt:    aluOp = aluSlt;
                    f3Or:     aluOp = aluOr;
                    f3And:    aluOp = aluAnd;
                    default:  regWrite = 1'b0;  // Outside the subset
                endcase
            end
            opImm: begin
                aluSrc   = 1'b1;
                regWrite = (funct3 == f3AddSub);  // addi only
            end
            opLoad: begin
                aluSrc   = 1'b1;
                regWrite = (funct3 == f3Word);
                wbSel    = wbMem;
            end
            opStore: begin
                imm      = sImm;
                aluSrc   = 1'b1;
                memWrite = (funct3 == f3Word);
            end
            opBranch: begin
                imm    = bImm;
                aluOp  = aluSub;  // Equal operands give zero
                branch = (funct3 == f3Beq);
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/dataMem.sv ====
module dataMem import isaPkg::*, ctrlPkg::*; #(
    parameter int dmemWords = 64
) (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            memWrite,
    input  wbSelE           wbSel,
    input  logic [xlen-1:0] aluResult,
    input  logic [xlen-1:0] storeData,
    output logic [xlen-1:0] wbData
);

    localparam int dAddrW = $clog2(dmemWords);

    logic [xlen-1:0]   mem [dmemWords];
    logic [dAddrW-1:0] wordIdx;
    logic [xlen-1:0]   loadData;

    // Byte address to word index modulo dmemWords
    assign wordIdx = aluResult[dAddrW+1:2];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < dmemWords; i++) begin
                mem[i] <= '0;
            end
        end else if (memWrite) begin
            mem[wordIdx] <= storeData;  // sw
        end
    end

    assign loadData = mem[wordIdx];  // lw

    // Writeback select
    always_comb begin
        case (wbSel)
            wbMem:   wbData = loadData;
            default: wbData = aluResult;
        endcase
    end

endmodule

// ==== hdl/registerFile.sv ====
module registerFile import isaPkg::*; (
    input  logic               CLK,
    input  logic               rstN,
    input  logic [regIdxW-1:0] rs1,
    input  logic [regIdxW-1:0] rs2,
    input  logic [regIdxW-1:0] rd,
    input  logic               regWrite,
    input  logic [xlen-1:0]    wbData,
    output logic [xlen-1:0]    rd1,
    output logic [xlen-1:0]    rd2
);

    localparam int regCount = 2 ** regIdxW;

    logic [xlen-1:0] regs [regCount];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (rd != '0)) begin  // x0 writes dropped
            regs[rd] <= wbData;
        end
    end

    // Combinational read ports
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/instMem.sv ====
module instMem import isaPkg::*; #(
    parameter int imemWords = 64
) (
    input  logic                         CLK,
    input  logic                         progWe,
    input  logic [$clog2(imemWords)-1:0] progAddr,
    input  logic [xlen-1:0]              progData,
    input  logic [xlen-1:0]              pc,
    output logic [xlen-1:0]              inst
);

    localparam int iAddrW = $clog2(imemWords);

    logic [xlen-1:0] mem [imemWords];

    // Program load port
    always_ff @(posedge CLK) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    // Upper PC bits wrap around the array on fetch
    assign inst = mem[pc[iAddrW+1:2]];

endmodule

// ==== hdl/ctrlPkg.sv ====
package ctrlPkg;

    // Operation performed by the ALU
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,  // Also used for beq compare
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4   // Signed set-less-than
    } aluOpE;

    // Source of the register writeback value
    typedef enum logic {
        wbAlu = 1'b0,
        wbMem = 1'b1
    } wbSelE;

endpackage

// ==== hdl/isaPkg.sv ====
package isaPkg;

    parameter int xlen    = 32;  // Data and address width
    parameter int regIdxW = 5;   // Register index width for 32 registers

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeE;

    // funct3 field of the R-type and I-type ALU operations
    typedef enum logic [2:0] {
        f3AddSub = 3'b000,
        f3Slt    = 3'b010,
        f3Or     = 3'b110,
        f3And    = 3'b111
    } funct3E;

    // Load/store and branch funct3 values share encodings with the ALU ones
    parameter funct3E f3Word = f3Slt;     // lw, sw
    parameter funct3E f3Beq  = f3AddSub;  // beq

endpackage
